/* logic/tx_consts.svh */
`ifndef TX_CONSTS_SVH
`define TX_CONSTS_SVH

// burst framing
// symbols carried by one start pulse
`define BURST_SYMBOLS 8

// clocks per symbol period, one level then zeros
`define SAMPLES_PER_SYMBOL 4

// zero clocks after the last symbol
// one per tap so the whole filter empties
`define FLUSH_CLKS 21

// shaping filter size
`define NUM_TAPS 21

// symmetric taps share coefficients
`define NUM_UNIQUE 11

// 4-ASK magnitudes in 1s17
// outer is 0.75 full scale
`define LEVEL_OUTER 98304

// inner is 0.25 full scale
`define LEVEL_INNER 32768

`endif

/* logic/tx_pkg.sv */
package tx_pkg;

`include "tx_consts.svh"

    // one baseband sample, 1s17
    typedef logic signed [17:0] sample_t;

    // one Gray coded 4-ASK symbol
    typedef logic [1:0] symbol_t;

    // whole burst word
    // element 0 in the low bits, sent first
    typedef symbol_t [`BURST_SYMBOLS-1:0] burst_t;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE,
        SEND,
        FLUSH
    } burst_state_t;

    // steering from the FSM to the mapper
    typedef struct packed {
        // advance to the next symbol on this clock
        logic sym_strobe;
        // burst symbols still going out
        logic sending;
        // capture a new burst word
        logic load;
    } tx_ctrl_t;

endpackage

/* logic/sample_timer.sv */
`include "tx_consts.svh"

module sample_timer (
    input  logic clk,
    input  logic reset,
    input  logic clear,
    input  logic run,
    output logic sym_tick,
    output logic last_sym,
    output logic flush_done
);

    localparam int PH_W  = $clog2(`SAMPLES_PER_SYMBOL);
    localparam int CNT_W = $clog2(`FLUSH_CLKS + 1);

    // position inside the symbol period
    logic [PH_W-1:0] phase;
    // symbols sent, then flush clocks
    logic [CNT_W-1:0] count;
    // count now tracks flush clocks
    logic flushing;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase    <= '0;
            count    <= '0;
            flushing <= 1'b0;
        end else if (clear) begin
            // symbol 0 already issued by the load
            phase    <= PH_W'(1);
            count    <= '0;
            flushing <= 1'b0;
        end else if (run) begin
            if (phase == PH_W'(`SAMPLES_PER_SYMBOL - 1))
                phase <= '0;
            else
                phase <= phase + 1'b1;
            // last symbol done, restart count for flush
            if (last_sym) begin
                count    <= '0;
                flushing <= 1'b1;
            end else if (flushing || sym_tick) begin
                count <= count + 1'b1;
            end
        end
    end

    // one clock ahead of each new symbol level
    assign sym_tick   = run && !flushing && (phase == '0);
    // final clock of the last symbol period
    assign last_sym   = sym_tick && (count == CNT_W'(`BURST_SYMBOLS - 1));
    assign flush_done = run && flushing && (count == CNT_W'(`FLUSH_CLKS - 1));

endmodule

/* logic/burst_ctrl.sv */
module burst_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              sym_tick,
    input  logic              last_sym,
    input  logic              flush_done,
    output logic              timer_clear,
    output logic              timer_run,
    output tx_pkg::tx_ctrl_t  ctrl,
    output logic              busy
);

    import tx_pkg::*;

    burst_state_t state;
    burst_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // start only taken here
                if (start)
                    next_state = SEND;
            end
            SEND: begin
                if (last_sym)
                    next_state = FLUSH;
            end
            FLUSH: begin
                // filter tail fully out
                if (flush_done)
                    next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // accepted start, same clock as the burst capture
    assign ctrl.load       = (state == IDLE) && start;
    assign ctrl.sending    = (state == SEND);
    // no strobe on the last tick, all symbols gone by then
    assign ctrl.sym_strobe = (state == SEND) && sym_tick && !last_sym;

    // timer restarts with each burst
    assign timer_clear = ctrl.load;
    assign timer_run   = (state != IDLE);

    // high through send and flush
    assign busy = (state != IDLE);

endmodule

/* logic/symbol_mapper.sv */
`include "tx_consts.svh"

module symbol_mapper (
    input  logic             clk,
    input  logic             reset,
    input  tx_pkg::burst_t   burst,
    input  tx_pkg::tx_ctrl_t ctrl,
    output tx_pkg::sample_t  x_in
);

    import tx_pkg::*;

    localparam sample_t LVL_OUTER = sample_t'(`LEVEL_OUTER);
    localparam sample_t LVL_INNER = sample_t'(`LEVEL_INNER);

    // symbols not yet sent, next one in the low bits
    burst_t pending;

    // Gray order, neighbours differ by one bit
    function automatic sample_t map_level(input symbol_t sym);
        case (sym)
            2'b00:   map_level = -LVL_OUTER;
            2'b01:   map_level = -LVL_INNER;
            2'b11:   map_level = LVL_INNER;
            default: map_level = LVL_OUTER;
        endcase
    endfunction

    // symbol 0 goes straight out on load, rest kept
    always_ff @(posedge clk) begin
        if (ctrl.load)
            pending <= burst_t'(burst >> $bits(symbol_t));
        else if (ctrl.sending && ctrl.sym_strobe)
            pending <= burst_t'(pending >> $bits(symbol_t));
    end

    // one level per symbol period, zeros in between
    always_ff @(posedge clk) begin
        if (reset)
            x_in <= '0;
        else if (ctrl.load)
            x_in <= map_level(burst[0]);
        else if (ctrl.sending && ctrl.sym_strobe)
            x_in <= map_level(pending[0]);
        else
            x_in <= '0;
    end

endmodule

/* logic/tx_filt.sv */
`include "tx_consts.svh"

module tx_filt (
    input  logic            clk,
    input  logic            reset,
    input  tx_pkg::sample_t x_in,
    output tx_pkg::sample_t y
);

    import tx_pkg::*;

    // pair sums in the first adder level
    localparam int L2 = (`NUM_UNIQUE + 1) / 2;
    // second adder level
    localparam int L3 = (L2 + 1) / 2;

    // coefficients, 0s18, b[10] is the centre tap
    localparam logic signed [17:0] COEF [0:`NUM_UNIQUE-1] = '{
        18'sd299,
        18'sd613,
        18'sd414,
        -18'sd786,
        -18'sd2608,
        -18'sd3424,
        -18'sd1082,
        18'sd5451,
        18'sd14715,
        18'sd22988,
        18'sd26311
    };

    // tap 0, halved input
    logic signed [17:0] tap0;
    // taps 1 to 20
    logic signed [17:0] dly [1:`NUM_TAPS-1];
    // folded tap pairs
    logic signed [17:0] pre [0:`NUM_UNIQUE-1];
    // full width products, 3s33
    logic signed [35:0] prod [0:`NUM_UNIQUE-1];
    logic signed [17:0] sum2 [0:L2-1];
    logic signed [17:0] sum3 [0:L3-1];
    logic signed [17:0] sum4;

    // 2s16 gives headroom for the pre-add
    assign tap0 = {x_in[17], x_in[17:1]};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `NUM_TAPS; i++)
                dly[i] <= '0;
        end else begin
            dly[1] <= tap0;
            for (int i = 2; i < `NUM_TAPS; i++)
                dly[i] <= dly[i-1];
        end
    end

    // fold around the centre tap
    always_comb begin
        pre[0] = tap0 + dly[`NUM_TAPS-1];
        for (int i = 1; i < `NUM_UNIQUE - 1; i++)
            pre[i] = dly[i] + dly[`NUM_TAPS-1-i];
        // centre has no partner
        pre[`NUM_UNIQUE-1] = dly[`NUM_UNIQUE-1];
    end

    always_comb begin
        for (int i = 0; i < `NUM_UNIQUE; i++)
            prod[i] = pre[i] * COEF[i];
    end

    // keep bits 33:16, back to 18 bits
    always_comb begin
        for (int i = 0; i < L2; i++) begin
            if (2 * i + 1 < `NUM_UNIQUE)
                sum2[i] = prod[2*i][33:16] + prod[2*i+1][33:16];
            else
                sum2[i] = prod[2*i][33:16];
        end
    end

    always_comb begin
        for (int i = 0; i < L3; i++) begin
            if (2 * i + 1 < L2)
                sum3[i] = sum2[2*i] + sum2[2*i+1];
            else
                sum3[i] = sum2[2*i];
        end
    end

    // last level adds all of level 3
    always_comb begin
        sum4 = '0;
        for (int i = 0; i < L3; i++)
            sum4 = sum4 + sum3[i];
    end

    always_ff @(posedge clk) begin
        if (reset)
            y <= '0;
        else
            y <= sum4;
    end

endmodule

/* logic/tx_shaping.sv */
module tx_shaping (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  tx_pkg::burst_t  burst,
    output tx_pkg::sample_t y,
    output logic            busy
);

    import tx_pkg::*;

    // FSM to timer
    logic timer_clear;
    logic timer_run;
    // timer back to FSM
    logic sym_tick;
    logic last_sym;
    logic flush_done;
    // FSM to mapper
    tx_ctrl_t ctrl;
    // upsampled symbol stream into the filter
    sample_t x_in;

    burst_ctrl burst_ctrl_inst (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .sym_tick    (sym_tick),
        .last_sym    (last_sym),
        .flush_done  (flush_done),
        .timer_clear (timer_clear),
        .timer_run   (timer_run),
        .ctrl        (ctrl),
        .busy        (busy)
    );

    sample_timer sample_timer_inst (
        .clk        (clk),
        .reset      (reset),
        .clear      (timer_clear),
        .run        (timer_run),
        .sym_tick   (sym_tick),
        .last_sym   (last_sym),
        .flush_done (flush_done)
    );

    symbol_mapper symbol_mapper_inst (
        .clk   (clk),
        .reset (reset),
        .burst (burst),
        .ctrl  (ctrl),
        .x_in  (x_in)
    );

    tx_filt tx_filt_inst (
        .clk   (clk),
        .reset (reset),
        .x_in  (x_in),
        .y     (y)
    );

endmodule

/* bench/tx_shaping_asserts.sv */
module tx_shaping_asserts (
    input logic                 clk,
    input logic                 reset,
    input tx_pkg::burst_state_t state,
    input tx_pkg::tx_ctrl_t     ctrl,
    input logic                 busy
);

    import tx_pkg::*;

    // count of failed control checks
    int fail_count = 0;

    // idle means not busy
    idle_not_busy: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE) |-> !busy)
    else begin
        fail_count = fail_count + 1;
        $error("busy high while FSM is idle");
    end

    // burst capture only from idle
    load_in_idle: assert property (@(posedge clk) disable iff (reset)
        ctrl.load |-> (state == IDLE))
    else begin
        fail_count = fail_count + 1;
        $error("load outside idle");
    end

    // single cycle load
    load_one_cycle: assert property (@(posedge clk) disable iff (reset)
        ctrl.load |=> !ctrl.load)
    else begin
        fail_count = fail_count + 1;
        $error("load held longer than one cycle");
    end

    // symbols advance only while sending
    strobe_in_send: assert property (@(posedge clk) disable iff (reset)
        ctrl.sym_strobe |-> (state == SEND))
    else begin
        fail_count = fail_count + 1;
        $error("symbol strobe outside send");
    end

endmodule

bind burst_ctrl tx_shaping_asserts tx_shaping_asserts_inst (
    .clk   (clk),
    .reset (reset),
    .state (state),
    .ctrl  (ctrl),
    .busy  (busy)
);

/* bench/tx_shaping_tb.sv */
`include "tx_consts.svh"

module tx_shaping_tb;

    import tx_pkg::*;

    localparam int SEND_CLKS    = `BURST_SYMBOLS * `SAMPLES_PER_SYMBOL;
    localparam int BUSY_CLKS    = SEND_CLKS + `FLUSH_CLKS;
    // about 12 bursts of 53 cycles plus the idle stretches
    localparam int TIMEOUT_CLKS = 1000;

    // reference coefficients, centre tap last
    localparam logic signed [17:0] COEF [0:`NUM_UNIQUE-1] = '{
        18'sd299, 18'sd613, 18'sd414, -18'sd786, -18'sd2608, -18'sd3424,
        -18'sd1082, 18'sd5451, 18'sd14715, 18'sd22988, 18'sd26311
    };

    logic    clk;
    logic    reset;
    logic    start;
    burst_t  burst;
    sample_t y;
    logic    busy;

    // reference model state
    sample_t x_model;
    sample_t hist [1:`NUM_TAPS-1];
    sample_t y_model;
    logic    busy_model;
    burst_t  cur_burst;
    int      busy_left;
    int      pos;
    int      accept_count;
    // what the DUT samples on the next edge
    logic    applied_start;
    burst_t  applied_burst;
    integer  seed;
    int      cycle_count;

    tx_shaping tx_shaping_inst (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .burst (burst),
        .y     (y),
        .busy  (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CLKS) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CLKS);
        $display("Result: FAILED");
        $fatal(1, "simulation timeout");
    end

    // sign from the high bit, inner magnitude when the low bit is set
    function automatic sample_t level_of(input symbol_t sym);
        sample_t mag;
        mag = sym[0] ? sample_t'(`LEVEL_INNER) : sample_t'(`LEVEL_OUTER);
        return sym[1] ? mag : -mag;
    endfunction

    task automatic compare_sample(input string name, input sample_t actual,
                                  input sample_t expected);
        if (actual !== expected) begin
            $display("ERROR time %0t: %s expected %0d got %0d", $time, name,
                     expected, actual);
            $display("Result: FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic compare_busy(input string name, input logic actual,
                                input logic expected);
        if (actual !== expected) begin
            $display("ERROR time %0t: %s expected %b got %b", $time, name,
                     expected, actual);
            $display("Result: FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // one clock edge of the reference model
    task automatic model_edge();
        sample_t            taps [0:`NUM_TAPS-1];
        sample_t            pre;
        logic signed [35:0] prod;
        sample_t            acc;
        // halved input into tap 0, 2s16
        taps[0] = x_model >>> 1;
        for (int i = 1; i < `NUM_TAPS; i++)
            taps[i] = hist[i];
        acc = '0;
        for (int i = 0; i < `NUM_UNIQUE; i++) begin
            if (i == `NUM_UNIQUE - 1)
                pre = taps[i];
            else
                pre = taps[i] + taps[`NUM_TAPS-1-i];
            prod = pre * COEF[i];
            acc  = acc + prod[33:16];
        end
        y_model = acc;
        for (int i = `NUM_TAPS - 1; i > 1; i--)
            hist[i] = hist[i-1];
        hist[1] = taps[0];
        // start only counts when idle
        if (busy_left > 0) begin
            busy_left--;
            pos++;
        end else if (applied_start) begin
            busy_left = BUSY_CLKS;
            pos       = 0;
            cur_burst = applied_burst;
            accept_count++;
        end
        // one level every fourth send clock, zero stuffed
        if (busy_left > 0 && pos < SEND_CLKS && pos % `SAMPLES_PER_SYMBOL == 0)
            x_model = level_of(cur_burst[pos / `SAMPLES_PER_SYMBOL]);
        else
            x_model = '0;
        busy_model = (busy_left > 0);
    endtask

    // drive on the rising edge, check at the falling edge
    task automatic step(input logic start_val, input burst_t burst_val);
        @(posedge clk);
        model_edge();
        start <= start_val;
        burst <= burst_val;
        applied_start = start_val;
        applied_burst = burst_val;
        @(negedge clk);
        compare_sample("y", y, y_model);
        compare_busy("busy", busy, busy_model);
    endtask

    task automatic run_burst(input burst_t word);
        step(1'b1, word);
        do
            step(1'b0, word);
        while (busy_model);
        repeat (3) step(1'b0, word);
        // filter tail fully drained
        compare_sample("y", y, '0);
    endtask

    // busy window, optional second start mid burst
    task automatic busy_window(input burst_t word, input int restart_at,
                               input burst_t other);
        step(1'b1, word);
        for (int i = 1; i <= BUSY_CLKS + 1; i++) begin
            step(i == restart_at, (i >= restart_at && restart_at > 0) ? other : word);
            compare_busy("busy", busy, i <= BUSY_CLKS);
        end
    endtask

    task automatic test_reset_idle();
        repeat (30) begin
            step(1'b0, '0);
            compare_sample("y", y, '0);
            compare_busy("busy", busy, 1'b0);
        end
    endtask

    task automatic test_back_to_back();
        burst_t word;
        int     target;
        for (int n = 0; n < 8; n++) begin
            word   = burst_t'($random(seed));
            target = accept_count + 1;
            // start held high, taken on the first idle cycle
            do
                step(1'b1, word);
            while (accept_count != target);
        end
        do
            step(1'b0, word);
        while (busy_model);
        repeat (3) step(1'b0, word);
    endtask

    initial begin
        reset         = 1'b1;
        start         = 1'b0;
        burst         = '0;
        applied_start = 1'b0;
        applied_burst = '0;
        x_model       = '0;
        y_model       = '0;
        busy_model    = 1'b0;
        cur_burst     = '0;
        busy_left     = 0;
        pos           = 0;
        accept_count  = 0;
        seed          = 91216;
        for (int i = 1; i < `NUM_TAPS; i++)
            hist[i] = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        test_reset_idle();
        // every symbol 10, +outer
        run_burst(16'hAAAA);
        // 00 01 11 10 from the low bits up, twice
        run_burst(16'hB4B4);
        busy_window(16'h1E2D, 0, 16'h1E2D);
        // second start lands in the middle of the send phase
        busy_window(16'h6C93, 20, 16'hFFFF);
        repeat (3) step(1'b0, '0);
        test_back_to_back();

        if (tx_shaping_inst.burst_ctrl_inst.tx_shaping_asserts_inst.fail_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("control timing assertions failed");
            $display("Result: FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

/* tx_shaping.f */
+incdir+logic
logic/tx_pkg.sv
logic/sample_timer.sv
logic/burst_ctrl.sv
logic/symbol_mapper.sv
logic/tx_filt.sv
logic/tx_shaping.sv
bench/tx_shaping_asserts.sv
bench/tx_shaping_tb.sv
